/* rtl/p3_pkg.sv */
package p3_pkg;

  // ======================================================================
  // Datapath widths
  // ======================================================================

  localparam int data_w   = 32;
  localparam int addr_w   = 5;
  localparam int num_regs = 32;
  localparam int shamt_w  = 5;   // Shift and rotate use the low bits of scr2

  // ======================================================================
  // Immediate forms for the second operand
  // ======================================================================

  typedef enum logic [1:0] {
    imm5_ze  = 2'd0,
    imm15_se = 2'd1,
    imm15_ze = 2'd2,
    imm20_se = 2'd3
  } imm_sel_e;

  // ======================================================================
  // Operation groups and operations within a group
  // ======================================================================

  // Opcodes arrive already decoded from the instruction word
  typedef enum logic [5:0] {
    op_alu_reg = 6'b100000,  // Register-register arithmetic and logic
    op_alu_imm = 6'b100001,  // Shift and rotate by immediate
    op_movi    = 6'b100010,
    op_addi    = 6'b101000,
    op_xori    = 6'b101011,
    op_ori     = 6'b101100
  } opcode_e;

  // Only meaningful for op_alu_reg and op_alu_imm
  typedef enum logic [4:0] {
    sub_add   = 5'd0,
    sub_sub   = 5'd1,
    sub_and   = 5'd2,
    sub_xor   = 5'd3,
    sub_or    = 5'd4,
    sub_slli  = 5'd8,
    sub_srli  = 5'd9,
    sub_rotri = 5'd11
  } sub_opcode_e;

endpackage

/* rtl/rf_if.sv */
interface rf_if;

  logic [p3_pkg::addr_w-1:0] read_address1;
  logic [p3_pkg::addr_w-1:0] read_address2;
  logic [p3_pkg::addr_w-1:0] write_address;
  logic                      read;
  logic                      write;
  logic [p3_pkg::data_w-1:0] write_data;
  logic [p3_pkg::data_w-1:0] read_data1;
  logic [p3_pkg::data_w-1:0] read_data2;

  // Register file side
  modport rf_slave (
    input  read_address1, read_address2, write_address,
    input  read, write, write_data,
    output read_data1, read_data2
  );

  // Datapath side that issues reads and write-backs
  modport rf_master (
    output read_address1, read_address2, write_address,
    output read, write, write_data,
    input  read_data1, read_data2
  );

endinterface

/* rtl/regfile.sv */
module regfile (
  input  logic clk,
  input  logic rst_n,
  rf_if.rf_slave rf
);

  logic [p3_pkg::data_w-1:0] regs [p3_pkg::num_regs];

  // ======================================================================
  // Registered read ports
  // ======================================================================

  // Reads see the contents from before a write on the same edge
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rf.read_data1 <= '0;
      rf.read_data2 <= '0;
    end else if (rf.read) begin
      rf.read_data1 <= regs[rf.read_address1];
      rf.read_data2 <= regs[rf.read_address2];
    end
  end

  // ======================================================================
  // Write port
  // ======================================================================

  // Register 0 is writable like any other
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < p3_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (rf.write) begin
      regs[rf.write_address] <= rf.write_data;
    end
  end

endmodule

/* rtl/alu32.sv */
module alu32 (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [p3_pkg::data_w-1:0] scr1,
  input  logic [p3_pkg::data_w-1:0] scr2,
  input  p3_pkg::opcode_e           opcode,
  input  p3_pkg::sub_opcode_e       sub_opcode,
  input  logic                      enable_execute,
  output logic [p3_pkg::data_w-1:0] alu_result,
  output logic                      alu_overflow
);

  logic [p3_pkg::data_w-1:0]   sum;
  logic [p3_pkg::data_w-1:0]   diff;
  logic [p3_pkg::shamt_w-1:0]  shamt;
  logic [2*p3_pkg::data_w-1:0] rot_wide;
  logic                        add_ovf;
  logic                        sub_ovf;
  logic [p3_pkg::data_w-1:0]   result_next;
  logic                        ovf_next;

  assign sum   = scr1 + scr2;
  assign diff  = scr1 - scr2;
  assign shamt = scr2[p3_pkg::shamt_w-1:0];

  // Shifting a doubled copy right gives the rotation in the low half
  assign rot_wide = {scr1, scr1} >> shamt;

  // Same-sign operands with a result of the other sign
  assign add_ovf = (scr1[p3_pkg::data_w-1] == scr2[p3_pkg::data_w-1]) &&
                   (sum[p3_pkg::data_w-1] != scr1[p3_pkg::data_w-1]);
  assign sub_ovf = (scr1[p3_pkg::data_w-1] != scr2[p3_pkg::data_w-1]) &&
                   (diff[p3_pkg::data_w-1] != scr1[p3_pkg::data_w-1]);

  // ======================================================================
  // Operation select
  // ======================================================================

  always_comb begin
    result_next = '0;  // Undefined combinations give 0
    ovf_next    = 1'b0;
    case (opcode)
      p3_pkg::op_alu_reg: begin
        case (sub_opcode)
          p3_pkg::sub_add: begin
            result_next = sum;
            ovf_next    = add_ovf;
          end
          p3_pkg::sub_sub: begin
            result_next = diff;
            ovf_next    = sub_ovf;
          end
          p3_pkg::sub_and: result_next = scr1 & scr2;
          p3_pkg::sub_or:  result_next = scr1 | scr2;
          p3_pkg::sub_xor: result_next = scr1 ^ scr2;
          default:         result_next = '0;
        endcase
      end
      p3_pkg::op_alu_imm: begin
        case (sub_opcode)
          p3_pkg::sub_slli:  result_next = scr1 << shamt;
          p3_pkg::sub_srli:  result_next = scr1 >> shamt;
          p3_pkg::sub_rotri: result_next = rot_wide[p3_pkg::data_w-1:0];
          default:           result_next = '0;
        endcase
      end
      p3_pkg::op_addi: begin
        result_next = sum;
        ovf_next    = add_ovf;
      end
      p3_pkg::op_ori:  result_next = scr1 | scr2;
      p3_pkg::op_xori: result_next = scr1 ^ scr2;
      p3_pkg::op_movi: result_next = scr2;
      default:         result_next = '0;
    endcase
  end

  // ======================================================================
  // Result register
  // ======================================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      alu_result   <= '0;
      alu_overflow <= 1'b0;
    end else if (enable_execute) begin
      alu_result   <= result_next;
      alu_overflow <= ovf_next;
    end
  end

endmodule

/* rtl/operand_mux.sv */
module operand_mux (
  input  logic [4:0]                imm_5bit,
  input  logic [14:0]               imm_15bit,
  input  logic [19:0]               imm_20bit,
  input  p3_pkg::imm_sel_e          imm_form,
  input  logic                      imm_reg_select,
  input  logic                      writeback_select,
  input  logic [p3_pkg::data_w-1:0] read_data2,
  input  logic [p3_pkg::data_w-1:0] alu_result,
  output logic [p3_pkg::data_w-1:0] scr2,
  output logic [p3_pkg::data_w-1:0] write_data
);

  logic [p3_pkg::data_w-1:0] imm_ext;

  // ======================================================================
  // Immediate extension
  // ======================================================================

  always_comb begin
    case (imm_form)
      p3_pkg::imm5_ze: begin
        imm_ext = {{(p3_pkg::data_w-5){1'b0}}, imm_5bit};
      end
      p3_pkg::imm15_se: begin
        imm_ext = {{(p3_pkg::data_w-15){imm_15bit[14]}}, imm_15bit};
      end
      p3_pkg::imm15_ze: begin
        imm_ext = {{(p3_pkg::data_w-15){1'b0}}, imm_15bit};
      end
      p3_pkg::imm20_se: begin
        imm_ext = {{(p3_pkg::data_w-20){imm_20bit[19]}}, imm_20bit};
      end
      default: imm_ext = '0;
    endcase
  end

  // ======================================================================
  // Operand and write-back select
  // ======================================================================

  assign scr2       = imm_reg_select ? imm_ext : read_data2;
  assign write_data = writeback_select ? scr2 : alu_result;  // scr2 path loads without the ALU

endmodule

/* rtl/p3_top.sv */
module p3_top (
  input  logic                      clk,
  input  logic                      rst_n,
  // Register file
  input  logic [p3_pkg::addr_w-1:0] read_address1,
  input  logic [p3_pkg::addr_w-1:0] read_address2,
  input  logic [p3_pkg::addr_w-1:0] write_address,
  input  logic                      enable_fetch,
  input  logic                      enable_writeback,
  // Immediate fields
  input  logic [4:0]                imm_5bit,
  input  logic [14:0]               imm_15bit,
  input  logic [19:0]               imm_20bit,
  // Operand and write-back select
  input  logic [1:0]                mux4to1_select,
  input  logic                      mux2to1_select,
  input  logic                      imm_reg_select,
  // ALU control
  input  logic                      enable_execute,
  input  logic [5:0]                opcode,
  input  logic [4:0]                sub_opcode,
  output logic [p3_pkg::data_w-1:0] alu_result,
  output logic                      alu_overflow
);

  logic [p3_pkg::data_w-1:0] scr2;

  rf_if rf ();

  // ======================================================================
  // Register file
  // ======================================================================

  assign rf.read_address1 = read_address1;
  assign rf.read_address2 = read_address2;
  assign rf.write_address = write_address;
  assign rf.read          = enable_fetch;
  assign rf.write         = enable_writeback;

  regfile u_regfile (
    .clk   (clk),
    .rst_n (rst_n),
    .rf    (rf.rf_slave)
  );

  // ======================================================================
  // Operand path and ALU
  // ======================================================================

  operand_mux u_operand_mux (
    .imm_5bit         (imm_5bit),
    .imm_15bit        (imm_15bit),
    .imm_20bit        (imm_20bit),
    .imm_form         (p3_pkg::imm_sel_e'(mux4to1_select)),
    .imm_reg_select   (imm_reg_select),
    .writeback_select (mux2to1_select),
    .read_data2       (rf.read_data2),
    .alu_result       (alu_result),
    .scr2             (scr2),
    .write_data       (rf.write_data)  // Goes back into the register file
  );

  // Result is registered, so write-back one cycle later sees it
  alu32 u_alu32 (
    .clk            (clk),
    .rst_n          (rst_n),
    .scr1           (rf.read_data1),
    .scr2           (scr2),
    .opcode         (p3_pkg::opcode_e'(opcode)),
    .sub_opcode     (p3_pkg::sub_opcode_e'(sub_opcode)),
    .enable_execute (enable_execute),
    .alu_result     (alu_result),
    .alu_overflow   (alu_overflow)
  );

endmodule

/* test/tb_p3_top.sv */
module tb_p3_top;

  // One line of the case file
  typedef struct packed {
    logic [4:0]                ra1;
    logic [4:0]                ra2;
    logic [4:0]                wa;
    logic [4:0]                imm5;
    logic [14:0]               imm15;
    logic [19:0]               imm20;
    logic [1:0]                form;
    logic                      irs;
    logic                      wbs;
    logic [5:0]                opcode;
    logic [4:0]                sub_opcode;
    logic [1:0]                wb;  // 0 no write, 1 write after execute, 2 write with next fetch
    logic [p3_pkg::data_w-1:0] exp_result;
    logic                      exp_ovf;
  } step_t;

  logic                      clk;
  logic                      rst_n;
  logic [p3_pkg::addr_w-1:0] read_address1;
  logic [p3_pkg::addr_w-1:0] read_address2;
  logic [p3_pkg::addr_w-1:0] write_address;
  logic                      enable_fetch;
  logic                      enable_writeback;
  logic [4:0]                imm_5bit;
  logic [14:0]               imm_15bit;
  logic [19:0]               imm_20bit;
  logic [1:0]                mux4to1_select;
  logic                      mux2to1_select;
  logic                      imm_reg_select;
  logic                      enable_execute;
  logic [5:0]                opcode;
  logic [4:0]                sub_opcode;
  logic [p3_pkg::data_w-1:0] alu_result;
  logic                      alu_overflow;

  step_t steps[$];
  logic  pending_wb  = 1'b0;
  int    cycle_count = 0;
  int    cycle_limit = 0;

  p3_top DUT (
    .clk              (clk),
    .rst_n            (rst_n),
    .read_address1    (read_address1),
    .read_address2    (read_address2),
    .write_address    (write_address),
    .enable_fetch     (enable_fetch),
    .enable_writeback (enable_writeback),
    .imm_5bit         (imm_5bit),
    .imm_15bit        (imm_15bit),
    .imm_20bit        (imm_20bit),
    .mux4to1_select   (mux4to1_select),
    .mux2to1_select   (mux2to1_select),
    .imm_reg_select   (imm_reg_select),
    .enable_execute   (enable_execute),
    .opcode           (opcode),
    .sub_opcode       (sub_opcode),
    .alu_result       (alu_result),
    .alu_overflow     (alu_overflow)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ======================================================================
  // Failure handling and checks
  // ======================================================================

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [p3_pkg::data_w-1:0] actual,
                             input logic [p3_pkg::data_w-1:0] expected);
    if (actual !== expected) begin
      $display("ERR %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      abort_run();
    end
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("Timeout: the cases did not finish within %0d cycles", cycle_limit);
      abort_run();
    end
  end

  // ======================================================================
  // Case file and micro-operation sequence
  // ======================================================================

  task automatic load_cases();
    int                        fd;
    int                        n;
    string                     line;
    logic [p3_pkg::data_w-1:0] f [0:13];
    step_t                     s;
    fd = $fopen("test/p3_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file test/p3_cases.txt");
      abort_run();
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin  // Skip blanks and comments
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                    f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
        if (n != 14) begin
          $display("Malformed line in the case file: %s", line);
          abort_run();
        end
        s.ra1        = f[0][4:0];
        s.ra2        = f[1][4:0];
        s.wa         = f[2][4:0];
        s.imm5       = f[3][4:0];
        s.imm15      = f[4][14:0];
        s.imm20      = f[5][19:0];
        s.form       = f[6][1:0];
        s.irs        = f[7][0];
        s.wbs        = f[8][0];
        s.opcode     = f[9][5:0];
        s.sub_opcode = f[10][4:0];
        s.wb         = f[11][1:0];
        s.exp_result = f[12];
        s.exp_ovf    = f[13][0];
        steps.push_back(s);
      end
    end
    $fclose(fd);
    if (steps.size() == 0) begin
      $display("The case file holds no cases");
      abort_run();
    end
  endtask

  // Fetch, execute, then check and optionally write back
  task automatic run_step(input step_t s);
    @(posedge clk);
    #1;
    enable_writeback = pending_wb;  // Delayed write shares the edge with this fetch
    enable_fetch     = 1'b1;
    read_address1    = s.ra1;
    read_address2    = s.ra2;

    @(posedge clk);
    #1;
    enable_fetch     = 1'b0;
    enable_writeback = 1'b0;
    write_address    = s.wa;
    imm_5bit         = s.imm5;
    imm_15bit        = s.imm15;
    imm_20bit        = s.imm20;
    mux4to1_select   = s.form;
    imm_reg_select   = s.irs;
    mux2to1_select   = s.wbs;
    opcode           = s.opcode;
    sub_opcode       = s.sub_opcode;
    enable_execute   = 1'b1;

    @(posedge clk);
    #1;
    enable_execute = 1'b0;
    check_value("alu_result", alu_result, s.exp_result);
    check_value("alu_overflow", {31'b0, alu_overflow}, {31'b0, s.exp_ovf});
    enable_writeback = (s.wb == 2'd1);
    pending_wb       = (s.wb == 2'd2);
  endtask

  initial begin
    rst_n            = 1'b0;
    read_address1    = '0;
    read_address2    = '0;
    write_address    = '0;
    enable_fetch     = 1'b0;
    enable_writeback = 1'b0;
    imm_5bit         = '0;
    imm_15bit        = '0;
    imm_20bit        = '0;
    mux4to1_select   = '0;
    mux2to1_select   = 1'b0;
    imm_reg_select   = 1'b0;
    enable_execute   = 1'b0;
    opcode           = '0;
    sub_opcode       = '0;

    load_cases();
    cycle_limit = 3 * steps.size() + 10 + 20;

    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_value("alu_result", alu_result, '0);
    check_value("alu_overflow", {31'b0, alu_overflow}, '0);

    foreach (steps[i]) begin
      run_step(steps[i]);
    end

    // Finish a write-back left over from the last case
    @(posedge clk);
    #1;
    enable_writeback = pending_wb;
    @(posedge clk);
    #1;
    enable_writeback = 1'b0;

    $display("TEST OK");
    $finish;
  end

endmodule

/* test/p3_cases.txt */
# Hex columns: ra1 ra2 wa imm5 imm15 imm20 form irs wbs opcode sub wb exp_result exp_ovf
# form: 0 imm5_ze, 1 imm15_se, 2 imm15_ze, 3 imm20_se; wb: 0 none, 1 write, 2 write with next fetch
00 01 00 00 0000 00000 0 0 0 20 00 0 00000000 0
# Immediate loads through movi and through the scr2 write-back path
00 00 01 1f 0000 00000 0 1 0 22 00 1 0000001f 0
00 00 02 00 4000 00000 1 1 0 22 00 1 ffffc000 0
00 00 03 00 4000 00000 2 1 0 22 00 1 00004000 0
00 00 04 00 0000 80000 3 1 0 22 00 1 fff80000 0
01 00 05 00 0000 7ffff 3 1 1 20 00 1 0008001e 0
01 00 06 00 3fff 00000 1 1 1 2b 00 1 00003fe0 0
00 02 00 00 0000 00000 0 0 0 20 00 0 ffffc000 0
03 00 00 00 0000 00000 0 0 0 20 00 0 00004000 0
04 00 00 00 0000 00000 0 0 0 20 00 0 fff80000 0
05 00 00 00 0000 00000 0 0 0 20 00 0 0007ffff 0
06 00 00 00 0000 00000 0 0 0 20 00 0 00003fff 0
01 00 00 00 0000 00000 0 0 0 20 00 0 0000001f 0
# Build r7 = 12345678 and r8 = 0f0f0f0f
00 00 07 00 0000 12345 3 1 0 22 00 1 00012345 0
07 00 07 0c 0000 00000 0 1 0 21 08 1 12345000 0
07 00 07 00 0678 00000 2 1 0 2c 00 1 12345678 0
00 00 08 00 0000 0f0f0 3 1 0 22 00 1 0000f0f0 0
08 00 08 0c 0000 00000 0 1 0 21 08 1 0f0f0000 0
08 00 08 00 0f0f 00000 2 1 0 2c 00 1 0f0f0f0f 0
# Register-register group
07 08 00 00 0000 00000 0 0 0 20 00 0 21436587 0
07 08 00 00 0000 00000 0 0 0 20 01 0 03254769 0
07 08 00 00 0000 00000 0 0 0 20 02 0 02040608 0
07 08 00 00 0000 00000 0 0 0 20 04 0 1f3f5f7f 0
07 08 00 00 0000 00000 0 0 0 20 03 0 1d3b5977 0
08 07 00 00 0000 00000 0 0 0 20 01 0 fcdab897 0
# Shifts and rotates by immediate
07 00 00 00 0000 00000 0 1 0 21 08 0 12345678 0
01 00 00 1f 0000 00000 0 1 0 21 08 0 80000000 0
07 00 00 04 0000 00000 0 1 0 21 09 0 01234567 0
02 00 00 1f 0000 00000 0 1 0 21 09 0 00000001 0
02 00 00 00 0000 00000 0 1 0 21 09 0 ffffc000 0
07 00 00 08 0000 00000 0 1 0 21 0b 0 78123456 0
07 00 00 00 0000 00000 0 1 0 21 0b 0 12345678 0
07 00 00 1f 0000 00000 0 1 0 21 0b 0 2468acf0 0
01 00 00 04 0000 00000 0 1 0 21 0b 0 f0000001 0
# addi, ori and xori
07 00 00 00 7ff0 00000 1 1 0 28 00 0 12345668 0
07 00 00 00 7ff0 00000 2 1 0 28 00 0 1234d668 0
07 00 00 00 4000 00000 1 1 0 2c 00 0 ffffd678 0
07 00 00 1f 0000 00000 0 1 0 2b 00 0 12345667 0
07 00 00 00 0000 80000 3 1 0 2b 00 0 edcc5678 0
# Signed overflow with r9 = 7fffffff and r10 = 80000000
00 00 09 00 0000 7ffff 3 1 0 22 00 1 0007ffff 0
09 00 09 0c 0000 00000 0 1 0 21 08 1 7ffff000 0
09 00 09 00 0fff 00000 2 1 0 2c 00 1 7fffffff 0
09 09 00 00 0000 00000 0 0 0 20 00 0 fffffffe 1
09 09 00 00 0000 00000 0 0 0 20 02 0 7fffffff 0
09 00 00 01 0000 00000 0 1 0 28 00 0 80000000 1
00 00 0a 00 0000 80000 3 1 0 22 00 1 fff80000 0
0a 00 0a 0c 0000 00000 0 1 0 21 08 1 80000000 0
0a 01 00 00 0000 00000 0 0 0 20 01 0 7fffffe1 1
0a 01 00 00 0000 00000 0 0 0 20 03 0 8000001f 0
04 02 00 00 0000 00000 0 0 0 20 00 0 fff7c000 0
# Write and fetch of the same register on one edge
00 00 0b 15 0000 00000 0 1 0 22 00 2 00000015 0
0b 00 00 00 0000 00000 0 0 0 20 00 0 00000000 0
0b 00 00 00 0000 00000 0 0 0 20 00 0 00000015 0
00 00 01 0a 0000 00000 0 1 0 22 00 2 0000000a 0
01 00 00 00 0000 00000 0 0 0 20 00 0 0000001f 0
01 00 00 00 0000 00000 0 0 0 20 00 0 0000000a 0

/* verilog.f */
rtl/p3_pkg.sv
rtl/rf_if.sv
rtl/regfile.sv
rtl/alu32.sv
rtl/operand_mux.sv
rtl/p3_top.sv
test/tb_p3_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the datapath testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f verilog.f --top-module tb_p3_top -o sim_p3

# The simulator exits non-zero on failure, so keep the log for the search below
./obj_dir/sim_p3 | tee sim.log

if grep -q "^TEST OK$" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
